//--- hdl/avmm_pkg.sv
`default_nettype none

package avmm_pkg;

   // ----------------------------------------------------------
   // Bus geometry
   localparam int AVMM_AW        = 12;               // Byte address
   localparam int AVMM_DW        = 32;
   localparam int AVMM_BE_W      = AVMM_DW / 8;      // Byte lanes
   localparam int AVMM_MAX_BURST = 8;
   localparam int AVMM_COUNT_W   = $clog2(AVMM_MAX_BURST) + 1;

   // ----------------------------------------------------------
   // Master to slave, 54 bits
   typedef struct packed {
      logic [AVMM_AW-1:0]      address;
      logic                    write;
      logic                    read;
      logic [AVMM_DW-1:0]      writedata;
      logic [AVMM_BE_W-1:0]    byteenable;
      logic [AVMM_COUNT_W-1:0] burstcount;
   } avmm_cmd_t;

   // Slave to master, 35 bits
   typedef struct packed {
      logic [AVMM_DW-1:0] readdata;
      logic               readdatavalid;
      logic               waitrequest;
      logic               busy;              // Bank outside idle
   } avmm_rsp_t;

endpackage

`default_nettype wire

//--- hdl/mem_pkg.sv
`default_nettype none

package mem_pkg;

   localparam int APP_DW     = 8;
   localparam int BANK_BYTES = 256;
   localparam int BANK_AW    = $clog2(BANK_BYTES);
   localparam int BANK_WORDS = BANK_BYTES / 4;       // 32-bit words
   localparam int WORD_AW    = $clog2(BANK_WORDS);

   typedef logic [APP_DW-1:0]  bank_byte_t;
   typedef logic [WORD_AW-1:0] word_addr_t;

   // Bank number from a byte address, aliases past the last bank
   function automatic int unsigned bank_index(input logic [15:0] byte_addr,
                                              input int unsigned num_banks);
      return (byte_addr >> BANK_AW) % num_banks;
   endfunction

   function automatic logic [BANK_AW-1:0] local_addr(input logic [15:0] byte_addr);
      return byte_addr[BANK_AW-1:0];
   endfunction

   function automatic word_addr_t word_index(input logic [BANK_AW-1:0] byte_addr);
      return byte_addr[BANK_AW-1:2];   // Drop lane bits
   endfunction

endpackage

`default_nettype wire

//--- hdl/avmm_bank_router.sv
`timescale 1ns/1ns
`default_nettype none

module avmm_bank_router
   import avmm_pkg::*;
   import mem_pkg::*;
#(
   parameter int NUM_BANKS = 4
) (
   input  logic      clk,
   input  logic      rst,
   input  avmm_cmd_t bus_cmd,
   output avmm_rsp_t bus_rsp,
   output avmm_cmd_t bank_cmd [NUM_BANKS],
   input  avmm_rsp_t bank_rsp [NUM_BANKS]
);

   localparam int IDX_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

   logic [IDX_W-1:0] live_idx;    // From the address on the bus now
   logic [IDX_W-1:0] lock_idx;
   logic [IDX_W-1:0] cmd_idx;
   logic [IDX_W-1:0] rsp_idx;
   logic             locked;
   logic             active;

   assign live_idx = IDX_W'(bank_index(16'(bus_cmd.address), NUM_BANKS));

   // Locked bank still working. Once it drops busy its last
   // readdatavalid, if any, is on the bus in this same cycle
   assign active = locked & bank_rsp[lock_idx].busy;

   assign cmd_idx = active ? lock_idx : live_idx;
   assign rsp_idx = locked ? lock_idx : live_idx;   // Covers the last data beat

   // ----------------------------------------------------------
   // Lock
   // ----------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         locked   <= 1'b0;
         lock_idx <= '0;
      end else if (!active) begin
         // A new burst may start in the release cycle
         locked   <= bus_cmd.read | bus_cmd.write;
         lock_idx <= live_idx;
      end
   end

   // ----------------------------------------------------------
   // Command fan-out
   // ----------------------------------------------------------
   always_comb begin
      for (int b = 0; b < NUM_BANKS; b++) begin
         bank_cmd[b] = bus_cmd;
         if (IDX_W'(b) != cmd_idx) begin
            bank_cmd[b].read  = 1'b0;
            bank_cmd[b].write = 1'b0;
         end
      end
   end

   // ----------------------------------------------------------
   // Response return
   // ----------------------------------------------------------
   always_comb begin
      bus_rsp.readdata      = bank_rsp[rsp_idx].readdata;
      bus_rsp.readdatavalid = bank_rsp[rsp_idx].readdatavalid;
      bus_rsp.waitrequest   = bank_rsp[cmd_idx].waitrequest;  // Bank the command goes to
      bus_rsp.busy          = 1'b0;   // Internal to the bank side only
   end

endmodule

`default_nettype wire

//--- hdl/dpram_bank.sv
`timescale 1ns/1ns
`default_nettype none

module dpram_bank
   import avmm_pkg::*;
   import mem_pkg::*;
(
   input  logic               clk,
   input  logic               rst,
   input  avmm_cmd_t          cmd,
   output avmm_rsp_t          rsp,
   input  logic [BANK_AW-1:0] app_addr,
   output bank_byte_t         app_data
);

   localparam int LANE_W = $clog2(AVMM_BE_W);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_FETCH,
      ST_WRITE,
      ST_READ
   } state_t;

   logic [AVMM_DW-1:0] ram [BANK_WORDS];

   state_t                  state;
   state_t                  next_state;
   word_addr_t              word_addr;
   logic [AVMM_COUNT_W-1:0] beat_cnt;
   logic [AVMM_COUNT_W-1:0] burst_len;
   logic                    last_beat;
   logic                    accept_wr;
   logic                    rvalid;

   logic [AVMM_DW-1:0] wmask;
   logic [AVMM_DW-1:0] wdata;
   logic [AVMM_DW-1:0] rdata_a;      // Port A word, one cycle behind word_addr

   logic [AVMM_DW-1:0] word_b;
   logic [LANE_W-1:0]  lane_b;

   // ----------------------------------------------------------
   // Bus handshake
   // ----------------------------------------------------------
   assign accept_wr = (state == ST_WRITE) && cmd.write;
   assign last_beat = beat_cnt == AVMM_COUNT_W'(burst_len - 1'b1);

   assign rsp.waitrequest   = !(accept_wr || (state == ST_IDLE && cmd.read));
   assign rsp.readdatavalid = rvalid;
   assign rsp.readdata      = rvalid ? rdata_a : '0;
   assign rsp.busy          = state != ST_IDLE;

   always_comb begin
      next_state = state;
      case (state)
         ST_IDLE: begin
            if (cmd.read) begin
               next_state = ST_READ;      // Accepted right here
            end else if (cmd.write) begin
               next_state = ST_FETCH;
            end
         end
         ST_FETCH: begin
            next_state = ST_WRITE;
         end
         ST_WRITE: begin
            if (cmd.write) begin
               next_state = last_beat ? ST_IDLE : ST_FETCH;
            end
         end
         ST_READ: begin
            if (last_beat) begin
               next_state = ST_IDLE;
            end
         end
         default: next_state = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= ST_IDLE;
         beat_cnt <= '0;
         rvalid   <= 1'b0;
      end else begin
         state  <= next_state;
         rvalid <= state == ST_READ;   // Lines up with rdata_a
         case (state)
            ST_IDLE:  beat_cnt <= '0;
            ST_WRITE: beat_cnt <= accept_wr ? beat_cnt + 1'b1 : beat_cnt;
            ST_READ:  beat_cnt <= beat_cnt + 1'b1;
            default:  beat_cnt <= beat_cnt;
         endcase
      end
   end

   // Burst start taken from the first beat, word steps wrap in the bank
   always_ff @(posedge clk) begin
      case (state)
         ST_IDLE: begin
            word_addr <= word_index(local_addr(16'(cmd.address)));
            burst_len <= cmd.burstcount;
         end
         ST_WRITE: begin
            if (accept_wr) begin
               word_addr <= word_addr_t'(word_addr + 1'b1);
            end
         end
         ST_READ: begin
            word_addr <= word_addr_t'(word_addr + 1'b1);
         end
         default: begin
            word_addr <= word_addr;
         end
      endcase
   end

   // ----------------------------------------------------------
   // RAM port A, read-modify-write
   // ----------------------------------------------------------
   always_comb begin
      for (int i = 0; i < AVMM_BE_W; i++) begin
         wmask[8*i +: 8] = {8{cmd.byteenable[i]}};
      end
   end

   assign wdata = (cmd.writedata & wmask) | (rdata_a & ~wmask);  // Old bytes kept

   always_ff @(posedge clk) begin
      if (accept_wr) begin
         ram[word_addr] <= wdata;
      end
      rdata_a <= ram[word_addr];
   end

   // ----------------------------------------------------------
   // RAM port B, byte reads
   // ----------------------------------------------------------
   always_ff @(posedge clk) begin
      word_b   <= ram[word_index(app_addr)];
      lane_b   <= app_addr[LANE_W-1:0];
      app_data <= word_b[APP_DW*lane_b +: APP_DW];   // Little-endian lanes
   end

endmodule

`default_nettype wire

//--- hdl/app_read_mux.sv
`timescale 1ns/1ns
`default_nettype none

module app_read_mux
   import mem_pkg::*;
#(
   parameter int NUM_BANKS = 4
) (
   input  logic               clk,
   input  logic               rst,
   input  logic [9:0]         app_addr,
   output logic [BANK_AW-1:0] bank_addr,
   input  bank_byte_t         bank_data [NUM_BANKS],
   output bank_byte_t         app_data
);

   localparam int IDX_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

   logic [IDX_W-1:0] idx_d1;
   logic [IDX_W-1:0] idx_d2;

   // Same local address to every bank
   assign bank_addr = local_addr(16'(app_addr));

   // ----------------------------------------------------------
   // Bank select follows the two-stage bank read
   // ----------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         idx_d1 <= '0;
         idx_d2 <= '0;
      end else begin
         idx_d1 <= IDX_W'(bank_index(16'(app_addr), NUM_BANKS));
         idx_d2 <= idx_d1;
      end
   end

   assign app_data = bank_data[idx_d2];

endmodule

`default_nettype wire

//--- hdl/dpram_subsys.sv
`timescale 1ns/1ns
`default_nettype none

module dpram_subsys
   import avmm_pkg::*;
   import mem_pkg::*;
#(
   parameter int NUM_BANKS = 4
) (
   input  logic       clk,
   input  logic       rst,

   // Processor bus
   input  avmm_cmd_t  bus_cmd,
   output avmm_rsp_t  bus_rsp,

   // Application byte port
   input  logic [9:0] app_addr,
   output bank_byte_t app_data
);

   avmm_cmd_t          bank_cmd [NUM_BANKS];
   avmm_rsp_t          bank_rsp [NUM_BANKS];
   logic [BANK_AW-1:0] bank_addr;
   bank_byte_t         bank_data [NUM_BANKS];

   // ----------------------------------------------------------
   // Bus side
   // ----------------------------------------------------------
   avmm_bank_router #(
      .NUM_BANKS (NUM_BANKS)
   ) i_avmm_bank_router (
      .clk      (clk),
      .rst      (rst),
      .bus_cmd  (bus_cmd),
      .bus_rsp  (bus_rsp),
      .bank_cmd (bank_cmd),
      .bank_rsp (bank_rsp)
   );

   // ----------------------------------------------------------
   // Memory banks
   // ----------------------------------------------------------
   for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
      dpram_bank i_dpram_bank (
         .clk      (clk),
         .rst      (rst),
         .cmd      (bank_cmd[b]),
         .rsp      (bank_rsp[b]),
         .app_addr (bank_addr),
         .app_data (bank_data[b])
      );
   end

   // ----------------------------------------------------------
   // Application side
   // ----------------------------------------------------------
   app_read_mux #(
      .NUM_BANKS (NUM_BANKS)
   ) i_app_read_mux (
      .clk       (clk),
      .rst       (rst),
      .app_addr  (app_addr),
      .bank_addr (bank_addr),
      .bank_data (bank_data),
      .app_data  (app_data)
   );

endmodule

`default_nettype wire

//--- testbench/tb_dpram_subsys.sv
`timescale 1ns/1ns
`default_nettype none

module tb_dpram_subsys
   import avmm_pkg::*;
();

   localparam int DRIVE_DLY  = 1;    // After the rising edge
   localparam int SAMPLE_DLY = 2;    // After the drive point, 1 ns before the next edge
   localparam int NUM_OPS    = 18;
   localparam int MEM_BYTES  = 1024;

   typedef enum logic [1:0] {
      OP_WRITE,
      OP_READ,
      OP_APP
   } op_kind_t;

   typedef struct packed {
      op_kind_t    kind;
      logic [11:0] addr;
      logic [7:0]  count;   // Bus beats, or number of application reads
      logic [3:0]  be;
   } op_t;

   logic       clk;
   logic       rst;
   avmm_cmd_t  bus_cmd;
   avmm_rsp_t  bus_rsp;
   logic [9:0] app_addr;
   logic [7:0] app_data;

   op_t         ops [NUM_OPS];
   logic [7:0]  model [MEM_BYTES];   // Byte image of all banks
   logic [31:0] rand_state = 32'd30;
   int          cycle_cnt = 0;
   int          timeout_cycles;

   dpram_subsys #(
      .NUM_BANKS (4)
   ) i_dpram_subsys (
      .clk      (clk),
      .rst      (rst),
      .bus_cmd  (bus_cmd),
      .bus_rsp  (bus_rsp),
      .app_addr (app_addr),
      .app_data (app_data)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------
   function automatic logic [31:0] next_rand();
      rand_state = rand_state * 32'd1103515245 + 32'd12345;
      return rand_state;
   endfunction

   // Byte index of a burst beat, 1 KB alias and wrap inside the 256-byte bank
   function automatic int word_base(input logic [11:0] start, input int beat);
      int bank;
      int word;
      bank = (int'(start) >> 8) % 4;
      word = ((int'(start) % 256) / 4 + beat) % 64;
      return bank * 256 + word * 4;
   endfunction

   function automatic logic [31:0] model_word(input logic [11:0] start, input int beat);
      int base;
      base = word_base(start, beat);
      return {model[base + 3], model[base + 2], model[base + 1], model[base]};
   endfunction

   // Random start, then step to the next byte that holds written data
   function automatic int pick_app_addr();
      int a;
      a = int'((next_rand() >> 8) % MEM_BYTES);
      for (int n = 0; n < MEM_BYTES; n++) begin
         if (!$isunknown(model[a])) begin
            break;
         end
         a = (a + 1) % MEM_BYTES;
      end
      return a;
   endfunction

   function automatic op_t make_op(input op_kind_t kind, input logic [11:0] addr,
                                   input int count, input logic [3:0] be);
      op_t op;
      op.kind  = kind;
      op.addr  = addr;
      op.count = 8'(count);
      op.be    = be;
      return op;
   endfunction

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp) else begin
         fail_run($sformatf("mismatch at %0t ns: %s expected %h, got %h",
                            $time, name, exp, act));
      end
   endtask

   task automatic model_write(input logic [11:0] start, input int beat,
                              input logic [3:0] be, input logic [31:0] data);
      int base;
      base = word_base(start, beat);
      for (int i = 0; i < 4; i++) begin
         if (be[i]) begin
            model[base + i] = data[8*i +: 8];   // Lane i is byte i
         end
      end
   endtask

   task automatic idle_bus();
      bus_cmd.read  = 1'b0;
      bus_cmd.write = 1'b0;
   endtask

   // ------------------------------------------------------------
   // Operations, each starts and ends at a drive point
   // ------------------------------------------------------------
   task automatic run_write(input op_t op);
      int          beat;
      logic [31:0] data;
      beat = 0;
      data = next_rand();
      bus_cmd.address    = op.addr;
      bus_cmd.write      = 1'b1;
      bus_cmd.byteenable = op.be;
      bus_cmd.burstcount = AVMM_COUNT_W'(op.count);
      bus_cmd.writedata  = data;
      while (beat < int'(op.count)) begin
         #SAMPLE_DLY;
         check_value("bus_rsp.readdatavalid", 32'd0, 32'(bus_rsp.readdatavalid));
         if (!bus_rsp.waitrequest) begin   // Beat taken on the coming edge
            model_write(op.addr, beat, op.be, data);
            beat++;
            data = next_rand();
         end
         @(posedge clk);
         #DRIVE_DLY;
         if (beat < int'(op.count)) begin
            bus_cmd.writedata = data;
         end else begin
            idle_bus();
         end
      end
   endtask

   task automatic run_read(input op_t op);
      int beat;
      bus_cmd.address    = op.addr;
      bus_cmd.read       = 1'b1;
      bus_cmd.burstcount = AVMM_COUNT_W'(op.count);
      #SAMPLE_DLY;
      while (bus_rsp.waitrequest) begin
         @(posedge clk);
         #DRIVE_DLY;
         #SAMPLE_DLY;
      end
      @(posedge clk);
      #DRIVE_DLY;
      idle_bus();
      // Cycle 0 accepted the command, data due in cycles 2 to count+1
      for (int cyc = 1; cyc <= int'(op.count) + 2; cyc++) begin
         #SAMPLE_DLY;
         if (cyc >= 2 && cyc <= int'(op.count) + 1) begin
            beat = cyc - 2;
            assert (bus_rsp.readdatavalid === 1'b1) else begin
               fail_run($sformatf("readdatavalid missing at %0t ns on beat %0d of read at %h",
                                  $time, beat, op.addr));
            end
            check_value("bus_rsp.readdata", model_word(op.addr, beat), bus_rsp.readdata);
         end else begin
            check_value("bus_rsp.readdatavalid", 32'd0, 32'(bus_rsp.readdatavalid));
            check_value("bus_rsp.readdata", 32'd0, bus_rsp.readdata);
         end
         @(posedge clk);
         #DRIVE_DLY;
      end
   endtask

   // Back-to-back application reads, each checked 2 cycles after its address
   task automatic run_app(input int count);
      int q[$];
      int a;
      for (int k = 0; k < count + 2; k++) begin
         if (k < count) begin
            a = pick_app_addr();
            app_addr = 10'(a);
            q.push_back(a);
         end
         #SAMPLE_DLY;
         if (k >= 2) begin
            a = q.pop_front();
            check_value($sformatf("app_data @%03h", a), 32'(model[a]), 32'(app_data));
         end
         @(posedge clk);
         #DRIVE_DLY;
      end
   endtask

   task automatic load_table();
      ops[0]  = make_op(OP_WRITE, 12'h010, 1, 4'hF);   // Full word, bank 0
      ops[1]  = make_op(OP_READ,  12'h010, 1, 4'h0);
      ops[2]  = make_op(OP_WRITE, 12'h010, 1, 4'b0101);  // Lanes 0 and 2 only
      ops[3]  = make_op(OP_READ,  12'h013, 1, 4'h0);   // Unaligned byte address, same word
      ops[4]  = make_op(OP_WRITE, 12'h020, 8, 4'hF);
      ops[5]  = make_op(OP_READ,  12'h020, 8, 4'h0);
      ops[6]  = make_op(OP_WRITE, 12'h1F8, 8, 4'hF);   // Wraps to bank 1 start
      ops[7]  = make_op(OP_READ,  12'h1F8, 8, 4'h0);
      ops[8]  = make_op(OP_WRITE, 12'h1FC, 3, 4'b0011);
      ops[9]  = make_op(OP_READ,  12'h1F8, 8, 4'h0);
      ops[10] = make_op(OP_WRITE, 12'h240, 2, 4'hF);   // Bank 2
      ops[11] = make_op(OP_WRITE, 12'h3C4, 1, 4'hF);   // Bank 3
      ops[12] = make_op(OP_WRITE, 12'h6A0, 1, 4'hF);   // Above 1 KB, lands in bank 2
      ops[13] = make_op(OP_READ,  12'h2A0, 1, 4'h0);
      ops[14] = make_op(OP_READ,  12'hE40, 2, 4'h0);   // Alias of 0x240
      ops[15] = make_op(OP_READ,  12'h3C4, 1, 4'h0);
      ops[16] = make_op(OP_APP,   12'h000, 32, 4'h0);
      ops[17] = make_op(OP_READ,  12'h010, 1, 4'h0);
   endtask

   // ------------------------------------------------------------
   // Watchdog
   // ------------------------------------------------------------
   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt > timeout_cycles) begin
         fail_run($sformatf("timeout: run did not finish within %0d cycles",
                            timeout_cycles));
      end
   end

   // ------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------
   initial begin
      int total;
      rst      = 1'b1;
      bus_cmd  = '0;
      app_addr = '0;
      for (int i = 0; i < MEM_BYTES; i++) begin
         model[i] = 'x;
      end
      load_table();
      total = 0;
      foreach (ops[i]) begin
         total += int'(ops[i].count);
      end
      timeout_cycles = 4 * total + 200;

      // Two reset edges, then a few idle cycles
      for (int i = 0; i < 5; i++) begin
         @(posedge clk);
         #DRIVE_DLY;
         if (i == 1) begin
            rst = 1'b0;
         end
         #SAMPLE_DLY;
         check_value("bus_rsp.waitrequest", 32'd1, 32'(bus_rsp.waitrequest));
         check_value("bus_rsp.readdatavalid", 32'd0, 32'(bus_rsp.readdatavalid));
      end
      @(posedge clk);
      #DRIVE_DLY;

      foreach (ops[i]) begin
         case (ops[i].kind)
            OP_WRITE: run_write(ops[i]);
            OP_READ:  run_read(ops[i]);
            default:  run_app(int'(ops[i].count));
         endcase
      end

      $display("Testbench passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
hdl/avmm_pkg.sv
hdl/mem_pkg.sv
hdl/avmm_bank_router.sv
hdl/dpram_bank.sv
hdl/app_read_mux.sv
hdl/dpram_subsys.sv
testbench/tb_dpram_subsys.sv
